// File: Makefile
# Verilator lint and simulation of the back end

SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module back_end -f backend.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_back_end \
		-f backend.f -Mdir obj_dir -o sim_back_end
	./obj_dir/sim_back_end | tee $(SIM_LOG)
	grep -q "Test passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: backend.f
hdl/backend_pkg.sv
hdl/backend_if.sv
hdl/gen_fifo.sv
hdl/dispatch.sv
hdl/alu_issue.sv
hdl/alu.sv
hdl/phy_register.sv
hdl/commit.sv
hdl/back_end.sv
test/tb_back_end.sv

// File: hdl/alu.sv
// single-cycle integer ALU, result registered as the writeback strobe
// shift amount is the low 5 bits of op2
`default_nettype none

module alu (
	input wire i_clk,
	input wire i_rst_n,
	exeparam_if.executor exe,
	output logic o_wb_valid,
	output logic [backend_pkg::PHY_AW-1:0] o_wb_rd_phy,
	output logic [backend_pkg::XLEN-1:0] o_wb_res
);

	logic [backend_pkg::XLEN-1:0] res;

	always_comb begin
		case (exe.op)
			backend_pkg::OP_ADD, backend_pkg::OP_ADDI: res = exe.op1 + exe.op2;
			backend_pkg::OP_SUB: res = exe.op1 - exe.op2;
			backend_pkg::OP_AND: res = exe.op1 & exe.op2;
			backend_pkg::OP_OR: res = exe.op1 | exe.op2;
			backend_pkg::OP_XOR, backend_pkg::OP_XORI: res = exe.op1 ^ exe.op2;
			backend_pkg::OP_SLL: res = exe.op1 << exe.op2[4:0];
			default: res = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_wb_valid <= 1'b0;
		else
			o_wb_valid <= exe.valid;
	end

	always_ff @(posedge i_clk) begin
		if (exe.valid) begin
			o_wb_rd_phy <= exe.rd_phy;
			o_wb_res <= res;
		end
	end

endmodule

`default_nettype wire

// File: hdl/alu_issue.sv
// in-order issue: the FIFO head waits until its sources are written back
// a blocked head holds everything behind it
`default_nettype none

module alu_issue (
	input wire i_clk,
	input wire i_rst_n,
	output logic o_issue_pop,
	input wire i_issue_empty,
	input wire [backend_pkg::ISSUE_DW-1:0] i_issue_info,
	input wire [2**backend_pkg::PHY_AW-1:0] i_wb_log,
	output logic [backend_pkg::PHY_AW-1:0] o_rs1_phy,
	output logic [backend_pkg::PHY_AW-1:0] o_rs2_phy,
	input wire [backend_pkg::XLEN-1:0] i_rs1_data,
	input wire [backend_pkg::XLEN-1:0] i_rs2_data,
	exeparam_if.issuer exe
);

	logic [3:0] op;
	logic [backend_pkg::PHY_AW-1:0] rd_phy;
	logic [backend_pkg::IMM_W-1:0] imm;
	logic [backend_pkg::XLEN-1:0] imm_ext;
	logic rs1_ok;
	logic rs2_ok;

	assign {op, rd_phy, o_rs1_phy, o_rs2_phy, imm} = i_issue_info;

	// register 0 is always ready
	assign rs1_ok = o_rs1_phy[backend_pkg::PHY_AW-1:backend_pkg::RP_AW] == '0
		|| i_wb_log[o_rs1_phy];
	assign rs2_ok = op[3] || o_rs2_phy[backend_pkg::PHY_AW-1:backend_pkg::RP_AW] == '0
		|| i_wb_log[o_rs2_phy];
	assign o_issue_pop = !i_issue_empty && rs1_ok && rs2_ok;

	assign imm_ext = {{(backend_pkg::XLEN - backend_pkg::IMM_W){imm[backend_pkg::IMM_W-1]}}, imm};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			exe.valid <= 1'b0;
		else
			exe.valid <= o_issue_pop;
	end

	always_ff @(posedge i_clk) begin
		if (o_issue_pop) begin
			exe.op <= op;
			exe.op1 <= i_rs1_data;
			exe.op2 <= op[3] ? imm_ext : i_rs2_data;
			exe.rd_phy <= rd_phy;
		end
	end

endmodule

`default_nettype wire

// File: hdl/back_end.sv
// one-lane out-of-order back end; input is an instruction FIFO with empty/pop
// no output back-pressure, at most one commit per cycle
`default_nettype none

module back_end (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_instr_empty,
	input wire backend_pkg::decode_instr_t i_instr,
	output logic o_instr_pop,
	output logic o_commit_valid,
	output logic [backend_pkg::ARCH_AW-1:0] o_commit_rd,
	output logic [backend_pkg::XLEN-1:0] o_commit_data
);

	rename_if rn_bus ();
	exeparam_if exe_bus ();

	logic issue_push, issue_full, issue_pop, issue_empty;
	logic [backend_pkg::ISSUE_DW-1:0] issue_in;
	logic [backend_pkg::ISSUE_DW-1:0] issue_out;
	logic rob_push, rob_full, rob_pop, rob_empty;
	logic [backend_pkg::ROB_DW-1:0] rob_in;
	logic [backend_pkg::ROB_DW-1:0] rob_out;

	logic wb_valid;
	logic [backend_pkg::PHY_AW-1:0] wb_rd_phy;
	logic [backend_pkg::XLEN-1:0] wb_res;
	logic [2**backend_pkg::PHY_AW-1:0] wb_log;

	logic [backend_pkg::PHY_AW-1:0] rs1_phy, rs2_phy, cm_phy;
	logic [backend_pkg::XLEN-1:0] rs1_data, rs2_data, cm_data;
	logic arch_set;
	logic [backend_pkg::ARCH_AW-1:0] arch_rd;
	logic [backend_pkg::RP_AW-1:0] arch_copy;

	dispatch dispatch_i (
		.i_clk, .i_rst_n, .i_instr_empty, .i_instr, .o_instr_pop,
		.rn(rn_bus.renamer),
		.o_issue_push(issue_push), .o_issue_info(issue_in), .i_issue_full(issue_full),
		.o_rob_push(rob_push), .o_rob_info(rob_in), .i_rob_full(rob_full)
	);

	gen_fifo #(.DW(backend_pkg::ISSUE_DW), .AW(backend_pkg::ISSUE_AW)) issue_fifo (
		.i_clk, .i_rst_n,
		.i_push(issue_push), .i_data(issue_in), .o_full(issue_full),
		.i_pop(issue_pop), .o_data(issue_out), .o_empty(issue_empty)
	);

	gen_fifo #(.DW(backend_pkg::ROB_DW), .AW(backend_pkg::ROB_AW)) reorder_fifo (
		.i_clk, .i_rst_n,
		.i_push(rob_push), .i_data(rob_in), .o_full(rob_full),
		.i_pop(rob_pop), .o_data(rob_out), .o_empty(rob_empty)
	);

	alu_issue alu_issue_i (
		.i_clk, .i_rst_n,
		.o_issue_pop(issue_pop), .i_issue_empty(issue_empty), .i_issue_info(issue_out),
		.i_wb_log(wb_log),
		.o_rs1_phy(rs1_phy), .o_rs2_phy(rs2_phy),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.exe(exe_bus.issuer)
	);

	alu alu_i (
		.i_clk, .i_rst_n,
		.exe(exe_bus.executor),
		.o_wb_valid(wb_valid), .o_wb_rd_phy(wb_rd_phy), .o_wb_res(wb_res)
	);

	// architectural table stays internal; only commit updates it
	phy_register phy_register_i (
		.i_clk, .i_rst_n,
		.rn(rn_bus.tables),
		.i_wb_valid(wb_valid), .i_wb_rd_phy(wb_rd_phy), .i_wb_res(wb_res),
		.i_rs1_phy(rs1_phy), .i_rs2_phy(rs2_phy),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
		.i_cm_phy(cm_phy), .o_cm_data(cm_data),
		.o_wb_log(wb_log),
		.i_arch_set(arch_set), .i_arch_rd(arch_rd), .i_arch_copy(arch_copy),
		.o_arch_copy_tbl()
	);

	commit commit_i (
		.i_clk, .i_rst_n,
		.o_rob_pop(rob_pop), .i_rob_empty(rob_empty), .i_rob_info(rob_out),
		.i_wb_log(wb_log), .o_cm_phy(cm_phy), .i_cm_data(cm_data),
		.o_arch_set(arch_set), .o_arch_rd(arch_rd), .o_arch_copy(arch_copy),
		.o_commit_valid, .o_commit_rd, .o_commit_data
	);

endmodule

`default_nettype wire

// File: hdl/backend_if.sv
// rename table bus and the issue-to-ALU strobe; neither has a ready
`default_nettype none

interface rename_if;
	logic [2**backend_pkg::ARCH_AW-1:0][backend_pkg::RP_AW-1:0] rn_act;
	logic [2**backend_pkg::PHY_AW-1:0] rn_used;
	logic rename_set;
	logic [backend_pkg::ARCH_AW-1:0] rename_rd;
	logic [backend_pkg::RP_AW-1:0] rename_copy;

	modport renamer (input rn_act, rn_used, output rename_set, rename_rd, rename_copy);
	// owner of the tables
	modport tables (output rn_act, rn_used, input rename_set, rename_rd, rename_copy);
endinterface

interface exeparam_if;
	logic valid;
	logic [3:0] op;
	logic [backend_pkg::XLEN-1:0] op1;
	logic [backend_pkg::XLEN-1:0] op2;
	logic [backend_pkg::PHY_AW-1:0] rd_phy;

	modport issuer (output valid, op, op1, op2, rd_phy);
	modport executor (input valid, op, op1, op2, rd_phy);
endinterface

`default_nettype wire

// File: hdl/backend_pkg.sv
// sizes, opcodes and the micro-instruction word shared by the whole back end
// register 0 is never renamed; its copy 0 always reads zero
`default_nettype none

package backend_pkg;

	localparam int XLEN     = 32;
	localparam int ARCH_AW  = 3;
	localparam int RP       = 4;
	localparam int RP_AW    = 2;
	localparam int PHY_AW   = ARCH_AW + RP_AW;
	localparam int ISSUE_AW = 2;
	localparam int ROB_AW   = 3;
	localparam int IMM_W    = 14;

	// opcodes at 8 and above take the immediate
	localparam logic [3:0] OP_ADD  = 4'd0;
	localparam logic [3:0] OP_SUB  = 4'd1;
	localparam logic [3:0] OP_AND  = 4'd2;
	localparam logic [3:0] OP_OR   = 4'd3;
	localparam logic [3:0] OP_XOR  = 4'd4;
	localparam logic [3:0] OP_SLL  = 4'd5;
	localparam logic [3:0] OP_ADDI = 4'd8;
	localparam logic [3:0] OP_XORI = 4'd9;

	// op, rd, rs1, rs2, imm
	localparam int ISSUE_DW = 4 + 3 * PHY_AW + IMM_W;
	// architectural rd and its copy
	localparam int ROB_DW   = ARCH_AW + RP_AW;

	typedef union packed {
		struct packed {
			logic [3:0]         op;
			logic [ARCH_AW-1:0] rd;
			logic [ARCH_AW-1:0] rs1;
			logic [ARCH_AW-1:0] rs2;
			logic [10:0]        unused;
		} r;
		struct packed {
			logic [3:0]         op;
			logic [ARCH_AW-1:0] rd;
			logic [ARCH_AW-1:0] rs1;
			logic [IMM_W-1:0]   imm;
		} i;
	} decode_instr_t;

endpackage

`default_nettype wire

// File: hdl/commit.sv
// retires the reorder head in program order, one per cycle at most
// rd 0 retires at once and always reports zero
`default_nettype none

module commit (
	input wire i_clk,
	input wire i_rst_n,
	output logic o_rob_pop,
	input wire i_rob_empty,
	input wire [backend_pkg::ROB_DW-1:0] i_rob_info,
	input wire [2**backend_pkg::PHY_AW-1:0] i_wb_log,
	output logic [backend_pkg::PHY_AW-1:0] o_cm_phy,
	input wire [backend_pkg::XLEN-1:0] i_cm_data,
	output logic o_arch_set,
	output logic [backend_pkg::ARCH_AW-1:0] o_arch_rd,
	output logic [backend_pkg::RP_AW-1:0] o_arch_copy,
	output logic o_commit_valid,
	output logic [backend_pkg::ARCH_AW-1:0] o_commit_rd,
	output logic [backend_pkg::XLEN-1:0] o_commit_data
);

	logic rd_zero;

	assign {o_arch_rd, o_arch_copy} = i_rob_info;
	assign o_cm_phy = i_rob_info;
	assign rd_zero = o_arch_rd == '0;

	assign o_rob_pop = !i_rob_empty && (rd_zero || i_wb_log[o_cm_phy]);
	assign o_arch_set = o_rob_pop && !rd_zero;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_commit_valid <= 1'b0;
		else
			o_commit_valid <= o_rob_pop;
	end

	always_ff @(posedge i_clk) begin
		if (o_rob_pop) begin
			o_commit_rd <= o_arch_rd;
			o_commit_data <= rd_zero ? '0 : i_cm_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dispatch.sv
// renames rd and pushes issue and reorder FIFOs in the cycle of the pop
// writes to register 0 keep copy 0 and never touch the rename tables
`default_nettype none

module dispatch (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_instr_empty,
	input wire backend_pkg::decode_instr_t i_instr,
	output logic o_instr_pop,
	rename_if.renamer rn,
	output logic o_issue_push,
	output logic [backend_pkg::ISSUE_DW-1:0] o_issue_info,
	input wire i_issue_full,
	output logic o_rob_push,
	output logic [backend_pkg::ROB_DW-1:0] o_rob_info,
	input wire i_rob_full
);

	logic [backend_pkg::RP-1:0] rd_used;
	logic [backend_pkg::RP_AW-1:0] free_copy;
	logic [backend_pkg::RP_AW-1:0] rd_copy;
	logic [backend_pkg::PHY_AW-1:0] rs1_phy;
	logic [backend_pkg::PHY_AW-1:0] rs2_phy;
	logic [backend_pkg::IMM_W-1:0] imm;
	logic has_free;
	logic is_imm;
	logic rd_zero;
	logic [9:0] stall_cnt;

	assign rd_used = rn.rn_used[i_instr.r.rd * backend_pkg::RP +: backend_pkg::RP];
	assign rd_zero = i_instr.r.rd == '0;
	assign is_imm = i_instr.r.op[3];

	// lowest free copy of rd
	always_comb begin
		has_free = 1'b0;
		free_copy = '0;
		for (int c = backend_pkg::RP - 1; c >= 0; c--) begin
			if (!rd_used[c]) begin
				has_free = 1'b1;
				free_copy = c[backend_pkg::RP_AW-1:0];
			end
		end
	end

	// sources see the table before this rename lands
	assign rs1_phy = {i_instr.r.rs1, rn.rn_act[i_instr.r.rs1]};
	assign rs2_phy = is_imm ? '0 : {i_instr.r.rs2, rn.rn_act[i_instr.r.rs2]};
	assign imm = is_imm ? i_instr.i.imm : '0;
	assign rd_copy = rd_zero ? '0 : free_copy;

	assign o_instr_pop = !i_instr_empty && !i_issue_full && !i_rob_full && (has_free || rd_zero);
	assign o_issue_push = o_instr_pop;
	assign o_rob_push = o_instr_pop;
	assign o_issue_info = {i_instr.r.op, i_instr.r.rd, rd_copy, rs1_phy, rs2_phy, imm};
	assign o_rob_info = {i_instr.r.rd, rd_copy};

	assign rn.rename_set = o_instr_pop && !rd_zero;
	assign rn.rename_rd = i_instr.r.rd;
	assign rn.rename_copy = free_copy;

	// consecutive cycles with work waiting but nothing popped
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			stall_cnt <= '0;
		else if (o_instr_pop || i_instr_empty)
			stall_cnt <= '0;
		else if (stall_cnt != '1)
			stall_cnt <= stall_cnt + 1'b1;
	end

	// a stall this long means the pipeline has deadlocked
	a_no_deadlock: assert property (@(posedge i_clk) disable iff (!i_rst_n) stall_cnt != '1)
		else $error("dispatch stalled without progress");

endmodule

`default_nettype wire

// File: hdl/gen_fifo.sv
// synchronous FIFO, 2**AW entries, head shown on o_data while not empty
// push while full and pop while empty are not allowed
`default_nettype none

module gen_fifo #(
	parameter int DW = 8,
	parameter int AW = 2
) (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_push,
	input wire [DW-1:0] i_data,
	output logic o_full,
	input wire i_pop,
	output logic [DW-1:0] o_data,
	output logic o_empty
);

	logic [DW-1:0] mem [2**AW];
	// top bit is the wrap flag
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	assign o_empty = wr_ptr == rd_ptr;
	assign o_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign o_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_push)
			mem[wr_ptr[AW-1:0]] <= i_data;
	end

	a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full)
		else $error("push into a full FIFO");
	a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty)
		else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// File: hdl/phy_register.sv
// physical file of RP copies per register with rename, writeback-log and
// architectural tables; writes aimed at register 0 are dropped
`default_nettype none

module phy_register (
	input wire i_clk,
	input wire i_rst_n,
	rename_if.tables rn,
	input wire i_wb_valid,
	input wire [backend_pkg::PHY_AW-1:0] i_wb_rd_phy,
	input wire [backend_pkg::XLEN-1:0] i_wb_res,
	input wire [backend_pkg::PHY_AW-1:0] i_rs1_phy,
	input wire [backend_pkg::PHY_AW-1:0] i_rs2_phy,
	output logic [backend_pkg::XLEN-1:0] o_rs1_data,
	output logic [backend_pkg::XLEN-1:0] o_rs2_data,
	input wire [backend_pkg::PHY_AW-1:0] i_cm_phy,
	output logic [backend_pkg::XLEN-1:0] o_cm_data,
	output logic [2**backend_pkg::PHY_AW-1:0] o_wb_log,
	input wire i_arch_set,
	input wire [backend_pkg::ARCH_AW-1:0] i_arch_rd,
	input wire [backend_pkg::RP_AW-1:0] i_arch_copy,
	output logic [2**backend_pkg::ARCH_AW-1:0][backend_pkg::RP_AW-1:0] o_arch_copy_tbl
);

	logic [backend_pkg::XLEN-1:0] rf [2**backend_pkg::PHY_AW];
	logic [2**backend_pkg::PHY_AW-1:0] wb_log;
	logic [2**backend_pkg::ARCH_AW-1:0][backend_pkg::RP_AW-1:0] arch_tbl;
	logic wb_we;

	assign wb_we = i_wb_valid && i_wb_rd_phy[backend_pkg::PHY_AW-1:backend_pkg::RP_AW] != '0;

	assign o_rs1_data = rf[i_rs1_phy];
	assign o_rs2_data = rf[i_rs2_phy];
	assign o_cm_data = rf[i_cm_phy];
	assign o_wb_log = wb_log;
	assign o_arch_copy_tbl = arch_tbl;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**backend_pkg::PHY_AW; i++)
				rf[i] <= '0;
		end else if (wb_we) begin
			rf[i_wb_rd_phy] <= i_wb_res;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rn.rn_act <= '0;
			arch_tbl <= '0;
			// copy 0 of each register starts live and written
			for (int i = 0; i < 2**backend_pkg::PHY_AW; i++) begin
				rn.rn_used[i] <= (i % backend_pkg::RP) == 0;
				wb_log[i] <= (i % backend_pkg::RP) == 0;
			end
		end else begin
			// retiring frees the copy it replaces
			if (i_arch_set) begin
				arch_tbl[i_arch_rd] <= i_arch_copy;
				rn.rn_used[{i_arch_rd, arch_tbl[i_arch_rd]}] <= 1'b0;
			end
			if (rn.rename_set) begin
				rn.rn_act[rn.rename_rd] <= rn.rename_copy;
				rn.rn_used[{rn.rename_rd, rn.rename_copy}] <= 1'b1;
				wb_log[{rn.rename_rd, rn.rename_copy}] <= 1'b0;
			end
			if (wb_we)
				wb_log[i_wb_rd_phy] <= 1'b1;
		end
	end

	a_wb_target: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		wb_we |-> rn.rn_used[i_wb_rd_phy] && !wb_log[i_wb_rd_phy])
		else $error("writeback to a free or already written copy");
	a_rename_free: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		rn.rename_set |-> !rn.rn_used[{rn.rename_rd, rn.rename_copy}])
		else $error("rename picked a copy still in use");

endmodule

`default_nettype wire

// File: test/tb_back_end.sv
// random micro-op streams against an 8-register architectural model
// commits are expected in program order, one per o_commit_valid
`default_nettype none

module tb_back_end;

	localparam int HALF = 50;
	localparam int QUARTER = 25;
	localparam int STREAM_LIMIT = 3000;
	localparam int DRAIN_LIMIT = 300;

	logic clk = 1'b0;
	logic rst_n;
	logic i_instr_empty;
	backend_pkg::decode_instr_t i_instr;
	logic o_instr_pop;
	logic o_commit_valid;
	logic [backend_pkg::ARCH_AW-1:0] o_commit_rd;
	logic [backend_pkg::XLEN-1:0] o_commit_data;

	integer seed = 32'h359e_beb9;
	string cur_test = "none";
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int pops = 0;
	int commits = 0;

	logic [backend_pkg::XLEN-1:0] arch [8];
	backend_pkg::decode_instr_t prog [$];
	logic [backend_pkg::ARCH_AW-1:0] exp_rd [$];
	logic [backend_pkg::XLEN-1:0] exp_data [$];

	back_end back_end_i (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_instr_empty, .i_instr, .o_instr_pop,
		.o_commit_valid, .o_commit_rd, .o_commit_data
	);

	always #(HALF) clk = ~clk;

	task count_error;
		test_errors++;
		total_errors++;
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [2:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return r[2:0];
	endfunction

	function automatic logic [backend_pkg::IMM_W-1:0] rand_imm();
		logic [31:0] r;
		r = $random(seed);
		return r[backend_pkg::IMM_W-1:0];
	endfunction

	function automatic logic [3:0] pick_r_op();
		case (rand_below(6))
			0: return backend_pkg::OP_ADD;
			1: return backend_pkg::OP_SUB;
			2: return backend_pkg::OP_AND;
			3: return backend_pkg::OP_OR;
			4: return backend_pkg::OP_XOR;
			default: return backend_pkg::OP_SLL;
		endcase
	endfunction

	function automatic backend_pkg::decode_instr_t make_r(input logic [3:0] op,
		input logic [2:0] rd, input logic [2:0] rs1, input logic [2:0] rs2);
		backend_pkg::decode_instr_t w;
		w = '0;
		w.r.op = op;
		w.r.rd = rd;
		w.r.rs1 = rs1;
		w.r.rs2 = rs2;
		return w;
	endfunction

	function automatic backend_pkg::decode_instr_t make_i(input logic [3:0] op,
		input logic [2:0] rd, input logic [2:0] rs1, input logic [13:0] imm);
		backend_pkg::decode_instr_t w;
		w = '0;
		w.i.op = op;
		w.i.rd = rd;
		w.i.rs1 = rs1;
		w.i.imm = imm;
		return w;
	endfunction

	// value that the op writes, from the current model state
	function automatic logic [31:0] expect_result(input backend_pkg::decode_instr_t w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_ext;
		a = arch[w.r.rs1];
		b = arch[w.r.rs2];
		imm_ext = {{18{w.i.imm[13]}}, w.i.imm};
		case (w.r.op)
			backend_pkg::OP_ADD: return a + b;
			backend_pkg::OP_SUB: return a - b;
			backend_pkg::OP_AND: return a & b;
			backend_pkg::OP_OR: return a | b;
			backend_pkg::OP_XOR: return a ^ b;
			backend_pkg::OP_SLL: return a << b[4:0];
			backend_pkg::OP_ADDI: return a + imm_ext;
			backend_pkg::OP_XORI: return a ^ imm_ext;
			default: return '0;
		endcase
	endfunction

	task automatic apply_model(input backend_pkg::decode_instr_t w);
		logic [31:0] v;
		v = expect_result(w);
		if (w.r.rd != 3'd0)
			arch[w.r.rd] = v;
		else
			v = '0;
		exp_rd.push_back(w.r.rd);
		exp_data.push_back(v);
	endtask

	// pop is read a quarter period after the falling edge, ahead of the rising one
	task automatic run_stream(input int gap_pct);
		int guard;
		guard = 0;
		while (prog.size() > 0 && guard < STREAM_LIMIT) begin
			@(negedge clk);
			i_instr = prog[0];
			i_instr_empty = rand_below(100) < gap_pct;
			#(QUARTER);
			if (o_instr_pop) begin
				apply_model(prog[0]);
				void'(prog.pop_front());
				pops++;
			end
			guard++;
		end
		@(negedge clk);
		i_instr_empty = 1'b1;
		if (prog.size() > 0) begin
			$display("[%s] timeout, input stream stalled with %0d ops left", cur_test,
				prog.size());
			count_error();
			prog.delete();
		end
	endtask

	task automatic wait_drain;
		int guard;
		guard = 0;
		while (exp_rd.size() > 0 && guard < DRAIN_LIMIT) begin
			@(posedge clk);
			guard++;
		end
		if (exp_rd.size() > 0) begin
			$display("[%s] timeout, %0d commits never arrived", cur_test, exp_rd.size());
			count_error();
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic finish_test;
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: ok, %0d commits so far", cur_test, commits);
		end else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", cur_test, test_errors);
		end
	endtask

	// commit outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst_n && o_commit_valid) begin
			commits++;
			if (exp_rd.size() == 0) begin
				$display("[%s] commit seen with no instruction outstanding", cur_test);
				count_error();
			end else begin
				assert (o_commit_rd == exp_rd[0]) else begin
					$display("** Error [%s] commit rd: expected %0d, actual %0d",
						cur_test, exp_rd[0], o_commit_rd);
					count_error();
				end
				assert (o_commit_data == exp_data[0]) else begin
					$display("** Error [%s] commit data: expected %h, actual %h",
						cur_test, exp_data[0], o_commit_data);
					count_error();
				end
				void'(exp_rd.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !o_instr_pop && !o_commit_valid)
		else begin
			$display("[%s] pop or commit active during reset", cur_test);
			count_error();
		end
	a_first_cycle: assert property (@(posedge clk) $rose(rst_n) |-> !o_instr_pop
		&& !o_commit_valid)
		else begin
			$display("[%s] pop or commit active right after reset", cur_test);
			count_error();
		end
	a_empty_no_pop: assert property (@(posedge clk) disable iff (!rst_n)
		i_instr_empty |-> !o_instr_pop)
		else begin
			$display("[%s] pop while the input was empty", cur_test);
			count_error();
		end
	a_rd0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		o_commit_valid && o_commit_rd == 3'd0 |-> o_commit_data == '0)
		else begin
			$display("** Error [%s] rd 0 data: expected 0, actual %h", cur_test, o_commit_data);
			count_error();
		end

	task automatic test_reset_idle;
		start_test("reset_idle");
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (20) @(negedge clk);
		assert (commits == 0) else begin
			$display("** Error [%s] commits: expected 0, actual %0d", cur_test, commits);
			count_error();
		end
		finish_test();
	endtask

	task automatic test_r_form;
		start_test("r_form");
		for (int r = 1; r < 8; r++)
			prog.push_back(make_i(backend_pkg::OP_ADDI, 3'(r), 3'd0, rand_imm()));
		repeat (40)
			prog.push_back(make_r(pick_r_op(), 3'(1 + rand_below(7)), rand_reg(), rand_reg()));
		run_stream(20);
		wait_drain();
		finish_test();
	endtask

	task automatic test_i_form;
		logic [13:0] imm;
		start_test("i_form");
		for (int n = 0; n < 30; n++) begin
			imm = rand_imm();
			// every third immediate negative
			if (n % 3 == 0)
				imm[13] = 1'b1;
			prog.push_back(make_i(rand_below(2) == 0 ? backend_pkg::OP_ADDI :
				backend_pkg::OP_XORI, 3'(1 + rand_below(7)), rand_reg(), imm));
		end
		run_stream(20);
		wait_drain();
		finish_test();
	endtask

	task automatic test_dep_chain;
		logic [2:0] prev;
		logic [2:0] rd;
		start_test("dep_chain");
		prev = 3'd1;
		prog.push_back(make_i(backend_pkg::OP_ADDI, prev, 3'd0, rand_imm()));
		for (int n = 1; n < 30; n++) begin
			rd = (n % 5 == 0) ? 3'd0 : 3'(1 + rand_below(7));
			if (n % 6 == 0)
				prog.push_back(make_r(backend_pkg::OP_ADD, rd, 3'd0, prev));
			else if (n % 4 == 0)
				prog.push_back(make_i(backend_pkg::OP_XORI, rd, prev, rand_imm()));
			else
				prog.push_back(make_r(pick_r_op(), rd, prev, rand_reg()));
			prev = rd;
		end
		run_stream(0);
		wait_drain();
		finish_test();
	endtask

	task automatic test_reuse_burst;
		start_test("reuse_burst");
		repeat (12)
			prog.push_back(make_i(rand_below(2) == 0 ? backend_pkg::OP_ADDI :
				backend_pkg::OP_XORI, 3'd5, 3'd5, rand_imm()));
		prog.push_back(make_r(backend_pkg::OP_ADD, 3'd6, 3'd5, 3'd5));
		run_stream(35);
		wait_drain();
		finish_test();
	endtask

	task automatic test_drain;
		start_test("drain");
		wait_drain();
		assert (commits == pops) else begin
			$display("** Error [%s] commit count: expected %0d, actual %0d", cur_test,
				pops, commits);
			count_error();
		end
		assert (exp_rd.size() == 0) else begin
			$display("[%s] expectations left over after the stream ended", cur_test);
			count_error();
		end
		finish_test();
	endtask

	initial begin
		rst_n = 1'b0;
		i_instr_empty = 1'b1;
		i_instr = '0;
		for (int r = 0; r < 8; r++)
			arch[r] = '0;
		test_reset_idle();
		test_r_form();
		test_i_form();
		test_dep_chain();
		test_reuse_burst();
		test_drain();
		$display("tests: %0d ok, %0d failing, %0d errors", tests_passed, tests_failed,
			total_errors);
		if (tests_failed == 0 && total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
